// File: list.f
hdl/board_pkg.sv
hdl/tick_gen.sv
hdl/key_sync.sv
hdl/key_press_counter.sv
hdl/display_scanner.sv
hdl/lab_top.sv
hdl/board_top.sv
verif/tb_board_top.sv

// File: Makefile
# Verilator build of the board wrapper testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits non-zero when the testbench stops with $fatal
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_board_top.sv
`timescale 1ns/10ps

module tb_board_top;

    localparam int tick_clks    = board_pkg::tick_period;
    localparam int sync_delay   = 3;   // Pin to internal level, worst case
    localparam int reset_cycles = 5;
    localparam int wrap_presses = 17;

    // Step limits in ticks
    localparam int led_wait_ticks = board_pkg::debounce_ticks + 2;
    localparam int press_ticks    = 2 * led_wait_ticks + 1;
    localparam int read_ticks     = board_pkg::w_lab_key + 1;
    localparam int all_read_ticks = board_pkg::w_lab_key * read_ticks;

    // Worst-case length of each test
    localparam int after_reset_ticks = 1 + board_pkg::w_lab_key + all_read_ticks;
    localparam int single_ticks      = board_pkg::w_lab_key * (press_ticks + all_read_ticks);
    localparam int bounce_ticks      = 1 + press_ticks + all_read_ticks;
    localparam int wrap_ticks        = 1 + wrap_presses * press_ticks + 2 * all_read_ticks;
    localparam int freeze_ticks      = 3 * press_ticks + all_read_ticks;
    localparam int clear_ticks       = 1 + press_ticks + all_read_ticks;
    localparam int total_ticks       = after_reset_ticks + single_ticks + bounce_ticks
                                     + wrap_ticks + freeze_ticks + clear_ticks;
    localparam int watchdog_clks     = (total_ticks + total_ticks / 4) * tick_clks;

    logic                          clk = 1'b0;
    logic [board_pkg::w_key - 1:0] key;
    board_pkg::key_vec_t           sw;
    logic [board_pkg::w_led - 1:0] led;
    board_pkg::digit_sel_t         digit;
    board_pkg::seg_t               hgfedcba;

    board_pkg::count_t count_model [board_pkg::w_lab_key];  // Expected press counts
    int                seed;

    board_top board_top_inst
    (
        .clk      ( clk      ),
        .key      ( key      ),
        .sw       ( sw       ),
        .led      ( led      ),
        .digit    ( digit    ),
        .hgfedcba ( hgfedcba )
    );

    always #2 clk = ~clk;

    task automatic stop_on_error;
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else
        begin
            $display("FAIL: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // Hex shapes in abcdefgh order, point off
    function automatic board_pkg::seg_t seg_pattern(input board_pkg::count_t value);
        board_pkg::seg_t shapes [16];
        shapes = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
                   8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};
        return shapes[value];
    endfunction

    function automatic board_pkg::seg_t reverse_bits(input board_pkg::seg_t bits);
        board_pkg::seg_t rev;
        for (int b = 0; b < $bits(board_pkg::seg_t); b++)
            rev[b] = bits[$bits(board_pkg::seg_t) - 1 - b];
        return rev;
    endfunction

    // Pins back to a hex value or -1 for an unknown shape
    function automatic int decode_pins(input board_pkg::seg_t pins);
        board_pkg::seg_t segs;
        int              value;
        segs  = reverse_bits(pins);
        value = -1;
        for (int v = 0; v < 16; v++)
            if (seg_pattern(board_pkg::count_t'(v)) == segs)
                value = v;
        return value;
    endfunction

    task automatic apply_reset;
        @(posedge clk);
        key[board_pkg::w_key - 1] <= 1'b0;  // Reset key pressed
        repeat (reset_cycles + sync_delay) @(posedge clk);
        key[board_pkg::w_key - 1] <= 1'b1;
        repeat (sync_delay) @(posedge clk);
        for (int i = 0; i < board_pkg::w_lab_key; i++)
            count_model[i] = '0;
    endtask

    // Pin level 0 means LED lit
    task automatic wait_led(input int i, input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (led[i] != level && waited < led_wait_ticks * tick_clks)
        begin
            @(negedge clk);
            waited++;
        end
        assert (led[i] == level)
        else
        begin
            $display("ERROR: LED %0d did not turn %s after key %0d changed",
                     i, level ? "off" : "on", i);
            stop_on_error();
        end
    endtask

    task automatic press_clean(input int i);
        @(posedge clk);
        key[i] <= 1'b0;
        wait_led(i, 1'b0);
        repeat (tick_clks) @(negedge clk);  // Hold one more tick
        check_value($sformatf("led[%0d] while held", i), 32'h0, 32'(led[i]));
        @(posedge clk);
        key[i] <= 1'b1;
        wait_led(i, 1'b1);
        if (sw[i])                          // Switch off means not frozen
            count_model[i] = board_pkg::count_t'(count_model[i] + 1'b1);
    endtask

    // Waits for a fresh activation so the pattern reflects the current count
    task automatic read_digit(input int i, output int value);
        int waited;
        waited = 0;
        @(negedge clk);
        while (digit[i] == 1'b0 && waited < read_ticks * tick_clks)
        begin
            @(negedge clk);
            waited++;
        end
        while (digit[i] == 1'b1 && waited < read_ticks * tick_clks)
        begin
            @(negedge clk);
            waited++;
        end
        assert (digit[i] == 1'b0)
        else
        begin
            $display("ERROR: digit %0d never became active within one refresh", i);
            stop_on_error();
        end
        check_value($sformatf("digit with digit %0d active", i),
                    32'(board_pkg::digit_sel_t'(~(board_pkg::digit_sel_t'(1) << i))),
                    32'(digit));
        value = decode_pins(hgfedcba);
        assert (value >= 0)
        else
        begin
            $display("FAIL: hgfedcba 0x%h on digit %0d is no hex digit", hgfedcba, i);
            stop_on_error();
        end
    endtask

    // Each digit must follow the previous one on the next tick
    task automatic check_scan_order;
        board_pkg::digit_sel_t previous;
        int                    waited;
        for (int k = 0; k < board_pkg::w_lab_key; k++)
        begin
            previous = digit;
            waited   = 0;
            while (digit == previous && waited <= tick_clks)
            begin
                @(negedge clk);
                waited++;
            end
            assert (digit != previous)
            else
            begin
                $display("ERROR: digit %0d did not become active one tick after the last", k);
                stop_on_error();
            end
            check_value($sformatf("digit in scan step %0d", k),
                        32'(board_pkg::digit_sel_t'(~(board_pkg::digit_sel_t'(1) << k))),
                        32'(digit));
        end
    endtask

    task automatic check_digits;
        int value;
        for (int i = 0; i < board_pkg::w_lab_key; i++)
        begin
            read_digit(i, value);
            check_value($sformatf("digit %0d value", i), 32'(count_model[i]), 32'(value));
        end
        check_value("led", 32'({board_pkg::w_led{1'b1}}), 32'(led));  // Nothing held
    endtask

    task automatic after_reset_state;
        apply_reset();
        @(negedge clk);
        check_value("digit before first tick", 32'({board_pkg::w_lab_key{1'b1}}),
                    32'(digit));
        check_scan_order();
        check_digits();
    endtask

    task automatic single_key_presses;
        for (int i = 0; i < board_pkg::w_lab_key; i++)
        begin
            press_clean(i);
            check_digits();
        end
    endtask

    // Short bounces within half a tick before a clean press
    task automatic bounced_press;
        int i;
        int segments;
        int len;
        i        = int'($unsigned($random(seed)) % board_pkg::w_lab_key);
        segments = 4 + 2 * int'($unsigned($random(seed)) % 3);
        @(posedge clk);
        for (int s = 0; s < segments; s++)
        begin
            len    = 1 + int'($unsigned($random(seed)) % (tick_clks / 16));
            key[i] <= (s % 2 == 0) ? 1'b0 : 1'b1;
            repeat (len) @(posedge clk);
        end
        press_clean(i);  // Stable hold and release
        check_digits();
    endtask

    task automatic count_wrap;
        int value;
        apply_reset();
        for (int n = 0; n < wrap_presses; n++)
            press_clean(3);
        read_digit(3, value);
        check_value("digit 3 after 17 presses", 32'h1, 32'(value));
        check_digits();
    endtask

    task automatic frozen_key;
        @(posedge clk);
        sw[1] <= 1'b0;  // Switch 1 on
        press_clean(1);
        press_clean(1);
        press_clean(2);
        check_digits();
        @(posedge clk);
        sw[1] <= 1'b1;
    endtask

    task automatic reset_clears_counts;
        press_clean(0);
        apply_reset();
        @(negedge clk);
        check_value("digit after reset", 32'({board_pkg::w_lab_key{1'b1}}), 32'(digit));
        check_digits();
    endtask

    initial
    begin
        repeat (watchdog_clks) @(posedge clk);
        $display("ERROR: watchdog expired, tests still running after %0d clocks",
                 watchdog_clks);
        stop_on_error();
    end

    initial
    begin
        seed = 88;
        key  <= '1;  // Buttons released
        sw   <= '1;  // Switches off
        for (int i = 0; i < board_pkg::w_lab_key; i++)
            count_model[i] = '0;

        after_reset_state();
        single_key_presses();
        bounced_press();
        count_wrap();
        frozen_key();
        reset_clears_counts();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: hdl/board_top.sv
`timescale 1ns/10ps

module board_top
(
    input                                 clk,
    input        [board_pkg::w_key - 1:0] key,
    input        board_pkg::key_vec_t     sw,
    output logic [board_pkg::w_led - 1:0] led,
    output board_pkg::digit_sel_t         digit,
    output board_pkg::seg_t               hgfedcba
);

    localparam int w_unused_led = board_pkg::w_led - board_pkg::w_lab_key;

    // Active-high side of the pins
    logic [board_pkg::w_key - 1:0] lab_key;
    board_pkg::key_vec_t           lab_sw;
    board_pkg::key_vec_t           lab_led;
    board_pkg::digit_sel_t         lab_digit;
    board_pkg::seg_t               abcdefgh;

    // Kit buttons and switches pull low when active
    assign lab_key = ~ key;
    assign lab_sw  = ~ sw;

    lab_top lab_top_inst
    (
        .clk      ( clk       ),
        .raw_key  ( lab_key   ),
        .raw_sw   ( lab_sw    ),
        .led      ( lab_led   ),
        .digit    ( lab_digit ),
        .abcdefgh ( abcdefgh  )
    );

    // LEDs light on a low pin; spare ones stay dark
    assign led   = { {w_unused_led {1'b1}}, ~ lab_led };

    assign digit = ~ lab_digit;  // Digit enables are active low

    // Segment pins are wired h first
    generate
        genvar i;

        for (i = 0; i < $bits(abcdefgh); i++)
        begin : seg_rev
            assign hgfedcba[i] = abcdefgh[$left(abcdefgh) - i];
        end
    endgenerate

endmodule

// File: hdl/lab_top.sv
`timescale 1ns/10ps

module lab_top
(
    input                                 clk,
    input        [board_pkg::w_key - 1:0] raw_key,
    input        board_pkg::key_vec_t     raw_sw,
    output board_pkg::key_vec_t           led,
    output board_pkg::digit_sel_t         digit,
    output board_pkg::seg_t               abcdefgh
);

    logic                  reset;
    logic                  tick;
    board_pkg::key_vec_t   key_level;
    board_pkg::key_vec_t   freeze;
    board_pkg::key_vec_t   pressed;

    // All counts side by side, key 0 in the low nibble
    logic [board_pkg::w_lab_key * board_pkg::w_count - 1:0] counts;

    key_sync key_sync_inst
    (
        .clk       ( clk       ),
        .raw_key   ( raw_key   ),
        .raw_sw    ( raw_sw    ),
        .reset     ( reset     ),
        .key_level ( key_level ),
        .freeze    ( freeze    )
    );

    tick_gen tick_gen_inst
    (
        .clk   ( clk   ),
        .reset ( reset ),
        .tick  ( tick  )
    );

    // One debounce and count unit per key
    generate
        genvar i;

        for (i = 0; i < board_pkg::w_lab_key; i++)
        begin : key_unit
            key_press_counter key_press_counter_inst
            (
                .clk       ( clk                                                ),
                .reset     ( reset                                              ),
                .tick      ( tick                                               ),
                .key_level ( key_level[i]                                       ),
                .freeze    ( freeze[i]                                          ),
                .pressed   ( pressed[i]                                         ),
                .count     ( counts[i * board_pkg::w_count +: board_pkg::w_count] )
            );
        end
    endgenerate

    display_scanner display_scanner_inst
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .tick     ( tick     ),
        .counts   ( counts   ),
        .digit    ( digit    ),
        .abcdefgh ( abcdefgh )
    );

    assign led = pressed;  // LED follows debounced key

endmodule

// File: hdl/display_scanner.sv
`timescale 1ns/10ps

module display_scanner
(
    input                                                        clk,
    input                                                        reset,
    input                                                        tick,
    input        [board_pkg::w_lab_key * board_pkg::w_count - 1:0] counts,
    output board_pkg::digit_sel_t                                digit,
    output board_pkg::seg_t                                      abcdefgh
);

    localparam logic [board_pkg::w_digit_idx - 1:0] idx_last =
        (board_pkg::w_digit_idx)'(board_pkg::w_lab_key - 1);

    logic [board_pkg::w_digit_idx - 1:0] idx;
    logic [board_pkg::w_digit_idx - 1:0] next_idx;
    board_pkg::digit_sel_t               next_digit;
    board_pkg::count_t                   next_count;

    // Hex shapes, b and d lower case, point off
    function automatic board_pkg::seg_t hex_to_seg(input board_pkg::count_t value);
        board_pkg::seg_t seg;
        case (value)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;  // F
        endcase
        return seg;
    endfunction

    // Start at digit 0 when nothing is selected yet
    always_comb
    begin
        if (digit == '0 || idx == idx_last)
            next_idx = '0;
        else
            next_idx = idx + 1'b1;

        next_digit = board_pkg::digit_sel_t'(1) << next_idx;
        next_count = counts[next_idx * board_pkg::w_count +: board_pkg::w_count];
    end

    // Select and pattern move together
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            digit    <= '0;
            idx      <= '0;
            abcdefgh <= '0;   // Blank
        end
        else if (tick)
        begin
            digit    <= next_digit;
            idx      <= next_idx;
            abcdefgh <= hex_to_seg(next_count);
        end
    end

endmodule

// File: hdl/key_press_counter.sv
`timescale 1ns/10ps

module key_press_counter
(
    input                       clk,
    input                       reset,
    input                       tick,
    input                       key_level,
    input                       freeze,
    output logic                pressed,
    output board_pkg::count_t   count
);

    localparam logic [board_pkg::w_debounce_cnt - 1:0] sample_last =
        (board_pkg::w_debounce_cnt)'(board_pkg::debounce_ticks - 1);

    board_pkg::debounce_state_t              state;
    logic [board_pkg::w_debounce_cnt - 1:0]  sample_cnt;  // Equal samples seen so far
    logic                                    press_pulse;

    // Level is only sampled on ticks
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= board_pkg::stable_low;
            sample_cnt  <= '0;
            pressed     <= 1'b0;
            press_pulse <= 1'b0;
        end
        else
        begin
            press_pulse <= 1'b0;

            if (tick)
            begin
                case (state)
                    board_pkg::stable_low:
                    begin
                        if (key_level)
                        begin
                            state      <= board_pkg::rising_check;
                            sample_cnt <= '0;
                        end
                    end

                    board_pkg::rising_check:
                    begin
                        if (!key_level)
                            state <= board_pkg::stable_low;  // Bounce, back to low
                        else if (sample_cnt == sample_last)
                        begin
                            state       <= board_pkg::stable_high;
                            pressed     <= 1'b1;
                            press_pulse <= 1'b1;
                        end
                        else
                            sample_cnt <= sample_cnt + 1'b1;
                    end

                    board_pkg::stable_high:
                    begin
                        if (!key_level)
                        begin
                            state      <= board_pkg::falling_check;
                            sample_cnt <= '0;
                        end
                    end

                    board_pkg::falling_check:
                    begin
                        if (key_level)
                            state <= board_pkg::stable_high;
                        else if (sample_cnt == sample_last)
                        begin
                            state   <= board_pkg::stable_low;
                            pressed <= 1'b0;
                        end
                        else
                            sample_cnt <= sample_cnt + 1'b1;
                    end

                    default:
                        state <= board_pkg::stable_low;
                endcase
            end
        end
    end

    // Count wraps at 16 by width
    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (press_pulse && !freeze)
            count <= count + 1'b1;
    end

endmodule

// File: hdl/key_sync.sv
`timescale 1ns/10ps

module key_sync
(
    input                                    clk,
    input        [board_pkg::w_key - 1:0]    raw_key,
    input        board_pkg::key_vec_t        raw_sw,
    output logic                             reset,
    output board_pkg::key_vec_t              key_level,
    output board_pkg::key_vec_t              freeze
);

    // Two stages per input
    logic [board_pkg::w_key - 1:0] key_meta;
    logic [board_pkg::w_key - 1:0] key_sync_q;
    board_pkg::key_vec_t           sw_meta;
    board_pkg::key_vec_t           sw_sync_q;

    // Every pin passes two flops
    always_ff @(posedge clk)
    begin
        key_meta   <= raw_key;
        key_sync_q <= key_meta;
        sw_meta    <= raw_sw;
        sw_sync_q  <= sw_meta;
    end

    // Top key drives the lab reset
    always_comb
    begin
        reset     = key_sync_q[board_pkg::w_key - 1];
        key_level = key_sync_q[board_pkg::w_lab_key - 1:0];
        freeze    = sw_sync_q;
    end

endmodule

// File: hdl/tick_gen.sv
`timescale 1ns/10ps

module tick_gen
(
    input        clk,
    input        reset,
    output logic tick
);

    localparam board_pkg::tick_cnt_t tick_last =
        board_pkg::tick_cnt_t'(board_pkg::tick_period - 1);

    board_pkg::tick_cnt_t cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (cnt == tick_last)
        begin
            cnt  <= '0;
            tick <= 1'b1;  // One pulse per period
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// File: hdl/board_pkg.sv
package board_pkg;

    // Board clock and pin counts
    localparam int clk_mhz   = 27;
    localparam int w_key     = 5;   // Last key is the reset
    localparam int w_lab_key = 4;   // Counting keys, digits and LEDs used
    localparam int w_led     = 6;

    // Scan and debounce timing
    localparam int tick_hz        = 1000;
    localparam int tick_period    = clk_mhz * 1000000 / tick_hz;
    localparam int debounce_ticks = 3;

    // Derived widths
    localparam int w_count        = 4;
    localparam int w_seg          = 8;
    localparam int w_tick_cnt     = $clog2(tick_period);
    localparam int w_debounce_cnt = $clog2(debounce_ticks);
    localparam int w_digit_idx    = $clog2(w_lab_key);

    typedef logic [w_count        - 1:0] count_t;
    typedef logic [w_seg          - 1:0] seg_t;        // abcdefgh, a is the MSB
    typedef logic [w_lab_key      - 1:0] digit_sel_t;  // One-hot
    typedef logic [w_lab_key      - 1:0] key_vec_t;
    typedef logic [w_tick_cnt     - 1:0] tick_cnt_t;

    // Debounce FSM of one key
    typedef enum logic [1:0]
    {
        stable_low,
        rising_check,
        stable_high,
        falling_check
    } debounce_state_t;

endpackage
